//--- build.f
logic/hsmc_pkg.sv
logic/button_debounce.sv
logic/video_serializer.sv
logic/panel_io_mux.sv
logic/hsmc_display_top.sv
verif/hsmc_display_chk.sv
verif/tb_hsmc_display.sv

//--- Makefile
TOP = tb_hsmc_display
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "simulation ended without passing"; exit 1)

lint:
	verilator --lint-only logic/hsmc_pkg.sv logic/button_debounce.sv \
		logic/video_serializer.sv logic/panel_io_mux.sv logic/hsmc_display_top.sv \
		--top-module hsmc_display_top
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_hsmc_display.sv
`timescale 1ns/1ns

module tb_hsmc_display import hsmc_pkg::*; ();

	localparam int DEBOUNCE_TIMEOUT = 16;
	localparam int NUM_PIXELS = 300;
	// sequence needs roughly 10000 cycles, allow twice that
	localparam int TIMEOUT_CYCLES = 20000;

	logic fpga_clk_50;
	logic rst_n;
	buttons_t fpga_button_pio;
	buttons_t debounced_buttons;
	pixel_word_t lcd_px;
	pixel_word_t vga_px;
	logic lcd_req;
	logic vga_req;
	logic lcd_ack;
	logic vga_ack;
	panel_beat_t lcd_beat;
	panel_beat_t vga_beat;
	vga_dac_t vga_dac;
	logic spi_sclk;
	logic spi_ss_n;
	logic cfg_en;
	logic cfg_scl;
	logic adc_cs_n;
	logic panel_dclk;
	logic panel_scen;

	// reference model state
	int cycles = 0;
	bit check_en = 1'b0;
	buttons_t exp_buttons;
	int btn_run [NUM_BUTTONS];
	logic exp_cs_n;
	logic exp_dclk;
	logic exp_scen;
	logic [1:0] ser_busy;
	logic [1:0] exp_ack;
	int ser_age [2]; // edges since capture
	int captured [2];
	panel_beat_t exp_beats [int]; // keyed by 2*cycle + display

	hsmc_display_top #(
		.DEBOUNCE_TIMEOUT(DEBOUNCE_TIMEOUT)
	) u_dut (
		.fpga_clk_50      (fpga_clk_50),
		.rst_n            (rst_n),
		.fpga_button_pio  (fpga_button_pio),
		.debounced_buttons(debounced_buttons),
		.lcd_px           (lcd_px),
		.lcd_req          (lcd_req),
		.lcd_ack          (lcd_ack),
		.lcd_beat         (lcd_beat),
		.vga_px           (vga_px),
		.vga_req          (vga_req),
		.vga_ack          (vga_ack),
		.vga_beat         (vga_beat),
		.vga_dac          (vga_dac),
		.spi_sclk         (spi_sclk),
		.spi_ss_n         (spi_ss_n),
		.cfg_en           (cfg_en),
		.cfg_scl          (cfg_scl),
		.adc_cs_n         (adc_cs_n),
		.panel_dclk       (panel_dclk),
		.panel_scen       (panel_scen)
	);

	initial begin
		fpga_clk_50 = 1'b0;
		forever #2 fpga_clk_50 = ~fpga_clk_50;
	end

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopping at cycle %0d", cycles);
	endtask

	task automatic check_buttons(input string name, input buttons_t got, input buttons_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_beat(input string name, input panel_beat_t got, input panel_beat_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_dac(input string name, input vga_dac_t got, input vga_dac_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	// k-th beat of a pixel, red leaves first
	function automatic panel_beat_t make_beat(input pixel_word_t w, input int k, input bit inv);
		panel_beat_t b;
		case (k)
			0: b.data = w.rgb[23:16];
			1: b.data = w.rgb[15:8];
			default: b.data = w.rgb[7:0];
		endcase
		b.den = w.blank;
		b.hs = w.hs ^ inv;
		b.vs = w.vs ^ inv;
		b.valid = 1'b1;
		return b;
	endfunction

	task automatic predict_beats(input int d, input pixel_word_t w, input logic req);
		if (ser_busy[d]) begin
			ser_age[d]++;
			if (ser_age[d] == 1) begin
				exp_ack[d] = 1'b1; // one cycle after capture
			end else if (ser_age[d] >= 4 && !req) begin
				exp_ack[d] = 1'b0; // last byte gone and req released
				ser_busy[d] = 1'b0;
			end
		end else if (req) begin
			for (int k = 0; k < 3; k++) begin
				exp_beats[2 * (cycles + 1 + k) + d] = make_beat(w, k, d == 0);
			end
			ser_busy[d] = 1'b1;
			ser_age[d] = 0;
			captured[d]++;
		end
	endtask

	task automatic inspect_beats(input int d, input panel_beat_t beat);
		int key;
		panel_beat_t e;
		key = 2 * cycles + d;
		if (exp_beats.exists(key)) begin
			e = exp_beats[key];
			check_beat(d == 0 ? "lcd_beat" : "vga_beat", beat, e);
			if (d == 1) begin
				check_dac("vga_dac", vga_dac, vga_dac_t'(e.data) << 2);
			end
			exp_beats.delete(key);
		end else begin
			check_bit(d == 0 ? "lcd_beat.valid" : "vga_beat.valid", beat.valid, 1'b0);
		end
	endtask

	// models advance on the rising edge with the inputs the DUT sees
	always @(posedge fpga_clk_50) begin
		cycles++;
		if (!rst_n) begin
			exp_buttons = '1;
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				btn_run[i] = 0;
			end
			exp_cs_n = 1'b1;
			exp_dclk = 1'b0;
			exp_scen = 1'b0;
			ser_busy = '0;
			exp_ack = '0;
			exp_beats.delete();
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				if (fpga_button_pio[i] == exp_buttons[i]) begin
					btn_run[i] = 0;
				end else begin
					btn_run[i]++; // stable cycles at the new level
					if (btn_run[i] == DEBOUNCE_TIMEOUT) begin
						exp_buttons[i] = fpga_button_pio[i];
						btn_run[i] = 0;
					end
				end
			end
			exp_cs_n = spi_ss_n;
			exp_scen = cfg_en;
			exp_dclk = !spi_ss_n ? spi_sclk : (!cfg_en ? cfg_scl : 1'b0);
			predict_beats(0, lcd_px, lcd_req);
			predict_beats(1, vga_px, vga_req);
			check_en = 1'b1;
		end
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	always @(negedge fpga_clk_50) begin
		if (check_en) begin
			check_buttons("debounced_buttons", debounced_buttons, exp_buttons);
			check_bit("adc_cs_n", adc_cs_n, exp_cs_n);
			check_bit("panel_dclk", panel_dclk, exp_dclk);
			check_bit("panel_scen", panel_scen, exp_scen);
			check_bit("lcd_ack", lcd_ack, exp_ack[0]);
			check_bit("vga_ack", vga_ack, exp_ack[1]);
			inspect_beats(0, lcd_beat);
			inspect_beats(1, vga_beat);
		end
	end

	task automatic run_buttons(input int rounds);
		logic [31:0] r;
		buttons_t target;
		for (int n = 0; n < rounds; n++) begin
			r = $urandom;
			target = r[NUM_BUTTONS-1:0];
			repeat ($urandom_range(0, DEBOUNCE_TIMEOUT - 1)) begin
				@(negedge fpga_clk_50);
				r = $urandom;
				fpga_button_pio = r[NUM_BUTTONS-1:0]; // contact bounce
			end
			@(negedge fpga_clk_50);
			fpga_button_pio = target;
			repeat (DEBOUNCE_TIMEOUT + 2) @(negedge fpga_clk_50);
			check_buttons("debounced_buttons", debounced_buttons, target);
			// glitch shorter than the filter must not get through
			fpga_button_pio = ~target;
			repeat ($urandom_range(1, DEBOUNCE_TIMEOUT - 1)) @(negedge fpga_clk_50);
			fpga_button_pio = target;
			@(negedge fpga_clk_50);
			check_buttons("debounced_buttons", debounced_buttons, target);
		end
	endtask

	task automatic drive_src(input int d, input pixel_word_t w, input logic req);
		if (d == 0) begin
			lcd_px = w;
			lcd_req = req;
		end else begin
			vga_px = w;
			vga_req = req;
		end
	endtask

	function automatic logic ack_of(input int d);
		return (d == 0) ? lcd_ack : vga_ack;
	endfunction

	task automatic send_pixels(input int d, input int count);
		logic [31:0] r;
		for (int n = 0; n < count; n++) begin
			while (ack_of(d)) @(negedge fpga_clk_50);
			r = $urandom;
			drive_src(d, r[$bits(pixel_word_t)-1:0], 1'b1);
			@(negedge fpga_clk_50);
			while (!ack_of(d)) @(negedge fpga_clk_50);
			repeat ($urandom_range(0, 6)) @(negedge fpga_clk_50); // req held past ack
			r = $urandom;
			drive_src(d, r[$bits(pixel_word_t)-1:0], 1'b0); // word no longer owned
			repeat ($urandom_range(0, 3)) @(negedge fpga_clk_50);
		end
	endtask

	task automatic run_panel(input int count);
		logic [31:0] r;
		repeat (count) begin
			@(negedge fpga_clk_50);
			r = $urandom;
			spi_ss_n = r[0];
			spi_sclk = r[1];
			cfg_en = r[2];
			cfg_scl = r[3];
		end
	endtask

	initial begin
		void'($urandom(79));
		rst_n = 1'b0;
		fpga_button_pio = '1;
		lcd_px = '0;
		vga_px = '0;
		lcd_req = 1'b0;
		vga_req = 1'b0;
		spi_sclk = 1'b0;
		spi_ss_n = 1'b1;
		cfg_en = 1'b1;
		cfg_scl = 1'b0;
		repeat (2) @(negedge fpga_clk_50);
		// values held by reset
		check_buttons("debounced_buttons", debounced_buttons, '1);
		check_bit("lcd_ack", lcd_ack, 1'b0);
		check_bit("vga_ack", vga_ack, 1'b0);
		check_beat("lcd_beat", lcd_beat, '0);
		check_beat("vga_beat", vga_beat, '0);
		check_bit("adc_cs_n", adc_cs_n, 1'b1);
		check_bit("panel_dclk", panel_dclk, 1'b0);
		check_bit("panel_scen", panel_scen, 1'b0);
		rst_n = 1'b1;
		run_buttons(40);
		send_pixels(0, NUM_PIXELS);
		send_pixels(1, NUM_PIXELS);
		run_panel(1000);
		repeat (8) @(negedge fpga_clk_50);
		if (exp_beats.num() != 0 || captured[0] != NUM_PIXELS || captured[1] != NUM_PIXELS) begin
			$display("pixel count wrong at end: lcd %0d, vga %0d, %0d beats never seen",
				captured[0], captured[1], exp_beats.num());
			stop_run();
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

//--- verif/hsmc_display_chk.sv
`timescale 1ns/1ns

module hsmc_display_chk import hsmc_pkg::*; (
	input logic fpga_clk_50,
	input logic rst_n,
	input logic req,
	input logic ack,
	input panel_beat_t beat,
	input ser_state_t state_q
);

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose without a request");

	// ack comes one cycle after the word was taken while idle
	ack_after_capture: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		$rose(ack) |-> $past(state_q, 2) == SER_IDLE && $past(req, 2))
		else $error("ack rose without a capture one cycle earlier");

	// handshake holds until the source lets go
	ack_held: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		ack && req |=> ack)
		else $error("ack dropped while req was still high");

	ack_fall_after_req: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		$fell(ack) |-> !$past(req))
		else $error("ack fell before req was low");

	// three beats per pixel, never more, never fewer
	valid_max_three: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		!(beat.valid && $past(beat.valid) && $past(beat.valid, 2) && $past(beat.valid, 3)))
		else $error("valid ran longer than three cycles");

	valid_min_three: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
		$fell(beat.valid) |-> $past(beat.valid, 2) && $past(beat.valid, 3))
		else $error("valid ran shorter than three cycles");

	quiet_in_reset: assert property (@(posedge fpga_clk_50)
		!rst_n |=> (beat == '0) && !ack)
		else $error("serializer outputs not cleared by reset");

endmodule

bind video_serializer hsmc_display_chk u_chk (
	.fpga_clk_50(fpga_clk_50),
	.rst_n      (rst_n),
	.req        (req),
	.ack        (ack),
	.beat       (beat),
	.state_q    (state_q)
);

//--- logic/hsmc_display_top.sv
`timescale 1ns/1ns

module hsmc_display_top import hsmc_pkg::*; #(
	parameter int DEBOUNCE_TIMEOUT = 50000 // 1 ms at 50 MHz
) (
	input  logic fpga_clk_50,
	input  logic rst_n,

	// board buttons, active low
	input  buttons_t fpga_button_pio,
	output buttons_t debounced_buttons,

	// LCD pixel source and panel side
	input  pixel_word_t lcd_px,
	input  logic lcd_req,
	output logic lcd_ack,
	output panel_beat_t lcd_beat,

	// VGA pixel source and DAC side
	input  pixel_word_t vga_px,
	input  logic vga_req,
	output logic vga_ack,
	output panel_beat_t vga_beat,
	output vga_dac_t vga_dac,

	// touch SPI and LCD config controls
	input  logic spi_sclk,
	input  logic spi_ss_n,
	input  logic cfg_en,
	input  logic cfg_scl,

	// shared panel pins
	output logic adc_cs_n,
	output logic panel_dclk,
	output logic panel_scen
);

	button_debounce #(
		.DEBOUNCE_TIMEOUT(DEBOUNCE_TIMEOUT)
	) u_debounce (
		.fpga_clk_50(fpga_clk_50),
		.rst_n      (rst_n),
		.raw        (fpga_button_pio),
		.clean      (debounced_buttons)
	);

	// LCD panel takes its syncs inverted
	video_serializer #(
		.SYNC_INVERT(1'b1)
	) u_lcd_ser (
		.fpga_clk_50(fpga_clk_50),
		.rst_n      (rst_n),
		.px         (lcd_px),
		.req        (lcd_req),
		.ack        (lcd_ack),
		.beat       (lcd_beat)
	);

	video_serializer #(
		.SYNC_INVERT(1'b0)
	) u_vga_ser (
		.fpga_clk_50(fpga_clk_50),
		.rst_n      (rst_n),
		.px         (vga_px),
		.req        (vga_req),
		.ack        (vga_ack),
		.beat       (vga_beat)
	);

	// DAC gets the byte on bits 9:2
	assign vga_dac = {vga_beat.data, {DAC_PAD_W{1'b0}}};

	panel_io_mux u_panel_mux (
		.fpga_clk_50(fpga_clk_50),
		.rst_n      (rst_n),
		.spi_sclk   (spi_sclk),
		.spi_ss_n   (spi_ss_n),
		.cfg_en     (cfg_en),
		.cfg_scl    (cfg_scl),
		.adc_cs_n   (adc_cs_n),
		.panel_dclk (panel_dclk),
		.panel_scen (panel_scen)
	);

endmodule

//--- logic/panel_io_mux.sv
`timescale 1ns/1ns

module panel_io_mux import hsmc_pkg::*; (
	input  logic fpga_clk_50,
	input  logic rst_n,
	input  logic spi_sclk,
	input  logic spi_ss_n,
	input  logic cfg_en,
	input  logic cfg_scl,
	output logic adc_cs_n,
	output logic panel_dclk,
	output logic panel_scen
);

	logic dclk_d;
	logic dclk_q;
	logic cs_n_q;
	logic scen_q;

	// touch controller wins the shared clock pin while selected
	always_comb begin
		if (!spi_ss_n) begin
			dclk_d = spi_sclk;
		end else if (!cfg_en) begin
			dclk_d = cfg_scl; // LCD config port owns the pin
		end else begin
			dclk_d = 1'b0;
		end
	end

	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			dclk_q <= 1'b0;
			cs_n_q <= 1'b1; // touch controller deselected
			scen_q <= 1'b0;
		end else begin
			dclk_q <= dclk_d;
			cs_n_q <= spi_ss_n;
			scen_q <= cfg_en;
		end
	end

	assign panel_dclk = dclk_q;
	assign adc_cs_n = cs_n_q;
	assign panel_scen = scen_q;

endmodule

//--- logic/video_serializer.sv
`timescale 1ns/1ns

module video_serializer import hsmc_pkg::*; #(
	parameter bit SYNC_INVERT = 1'b0
) (
	input  logic fpga_clk_50,
	input  logic rst_n,
	input  pixel_word_t px,
	input  logic req,
	output logic ack,
	output panel_beat_t beat
);

	ser_state_t state_q;
	ser_state_t state_d;

	pixel_word_t px_q; // word held while its bytes go out
	panel_byte_t byte_sel;
	panel_beat_t beat_d;
	panel_beat_t beat_q;
	logic ack_q;
	logic capture;

	// a new word is only taken while idle
	assign capture = (state_q == SER_IDLE) && req;

	always_comb begin
		state_d = state_q;
		case (state_q)
			SER_IDLE: begin
				if (req) begin
					state_d = SER_BYTE_R;
				end
			end
			SER_BYTE_R: state_d = SER_BYTE_G;
			SER_BYTE_G: state_d = SER_BYTE_B;
			SER_BYTE_B: state_d = SER_WAIT_REQ_LOW;
			SER_WAIT_REQ_LOW: begin
				// source still holds req, stall here
				if (!req) begin
					state_d = SER_IDLE;
				end
			end
			default: state_d = SER_IDLE;
		endcase
	end

	// color byte for the current phase
	always_comb begin
		byte_sel = '0;
		case (state_q)
			SER_BYTE_R: byte_sel = px_q.rgb[2*BYTE_W +: BYTE_W];
			SER_BYTE_G: byte_sel = px_q.rgb[BYTE_W +: BYTE_W];
			SER_BYTE_B: byte_sel = px_q.rgb[0 +: BYTE_W];
			default: byte_sel = '0;
		endcase
	end

	always_comb begin
		beat_d = '0;
		if (state_q inside {SER_BYTE_R, SER_BYTE_G, SER_BYTE_B}) begin
			beat_d.data = byte_sel;
			beat_d.den = px_q.blank;
			beat_d.hs = px_q.hs ^ SYNC_INVERT; // LCD wants active-high syncs
			beat_d.vs = px_q.vs ^ SYNC_INVERT;
			beat_d.valid = 1'b1;
		end
	end

	always_ff @(posedge fpga_clk_50) begin
		if (capture) begin
			px_q <= px;
		end
	end

	always_ff @(posedge fpga_clk_50) begin
		if (!rst_n) begin
			state_q <= SER_IDLE;
			beat_q <= '0;
			ack_q <= 1'b0;
		end else begin
			state_q <= state_d;
			beat_q <= beat_d;
			if (state_q == SER_BYTE_R) begin
				ack_q <= 1'b1; // one cycle after capture
			end else if (state_q == SER_WAIT_REQ_LOW && !req) begin
				ack_q <= 1'b0;
			end
		end
	end

	assign ack = ack_q;
	assign beat = beat_q;

endmodule

//--- logic/button_debounce.sv
`timescale 1ns/1ns

module button_debounce import hsmc_pkg::*; #(
	parameter int DEBOUNCE_TIMEOUT = 50000
) (
	input  logic fpga_clk_50,
	input  logic rst_n,
	input  buttons_t raw,
	output buttons_t clean
);

	// room for the full timeout value
	localparam int CNT_W = $clog2(DEBOUNCE_TIMEOUT + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	// count value on the last cycle of a stable interval
	localparam cnt_t CNT_LAST = cnt_t'(DEBOUNCE_TIMEOUT - 1);

	genvar i;
	generate
		for (i = 0; i < NUM_BUTTONS; i++) begin : g_btn
			logic clean_q;
			cnt_t cnt_q;

			// cnt_q counts cycles where the input disagrees with the output
			always_ff @(posedge fpga_clk_50) begin
				if (!rst_n) begin
					clean_q <= 1'b1; // released, buttons are active low
					cnt_q <= '0;
				end else begin
					if (raw[i] == clean_q) begin
						cnt_q <= '0; // bounced back, start over
					end else if (cnt_q == CNT_LAST) begin
						clean_q <= raw[i];
						cnt_q <= '0;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
			end

			assign clean[i] = clean_q;
		end
	endgenerate

endmodule

//--- logic/hsmc_pkg.sv
package hsmc_pkg;

	// board buttons on the HSMC side
	localparam int NUM_BUTTONS = 2;

	localparam int PIXEL_W = 24; // 8 bits per color
	localparam int BYTE_W = 8;
	localparam int DAC_W = 10;

	// the panel byte sits on the upper DAC bits
	localparam int DAC_PAD_W = DAC_W - BYTE_W;

	typedef logic [NUM_BUTTONS-1:0] buttons_t;
	typedef logic [PIXEL_W-1:0] pixel_t; // red on top, blue at the bottom
	typedef logic [BYTE_W-1:0] panel_byte_t;
	typedef logic [DAC_W-1:0] vga_dac_t;

	// one pixel with its timing flags, as the video source hands it over
	typedef struct packed {
		pixel_t rgb;
		logic blank; // high during active video
		logic hs;
		logic vs;
	} pixel_word_t;

	// one byte-per-cycle output beat toward a panel
	typedef struct packed {
		panel_byte_t data;
		logic den;
		logic hs;
		logic vs;
		logic valid;
	} panel_beat_t;

	typedef enum logic [2:0] {
		SER_IDLE,
		SER_BYTE_R,
		SER_BYTE_G,
		SER_BYTE_B,
		SER_WAIT_REQ_LOW
	} ser_state_t;

endpackage
